// ==== design/rv_pkg.sv ====
/*
 * Shared widths, opcodes and record types for the RV32I core.
 * Only the integer base set without loads, stores and system ops.
 * The reset PC must be word aligned; the core clears PC bits 1:0.
 */
package rv_pkg;

    // Widths ------------------------------
    localparam int XLEN_W     = 32;             // Data width
    localparam int REG_ADDR_W = 5;              // Register index width

    typedef logic [XLEN_W-1:0]     word_t;      // Data or instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register index
    typedef logic [6:0]            opcode_t;    // Major opcode field

    localparam word_t PC_RESET_ADDR = 32'h0000_0100; // First fetch address

    // Opcodes -----------------------------
    localparam opcode_t OPC_OP     = 7'b0110011; // Reg-reg ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011; // Reg-imm ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011; // All six conditional branches

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // Records -----------------------------
    typedef struct packed {
        reg_addr_t rs1;         // Left source, x0 for LUI
        reg_addr_t rs2;         // Right source
        reg_addr_t rd;          // Destination
        logic      rd_wen;      // Writes rd
        word_t     imm;         // Sign extended immediate
        alu_op_e   alu_op;
        logic      lhs_pc;      // Left operand is the PC
        logic      rhs_imm;     // Right operand is the immediate
        br_op_e    br_op;       // BR_NONE when not a branch
        logic      jal;
        logic      jalr;
        logic      illegal;     // Unknown encoding, retires as no-op
    } decoded_t;

    typedef struct packed {
        word_t     pc;          // PC of the retired instruction
        word_t     instr;       // Raw instruction word
        logic      rd_wen;
        reg_addr_t rd;
        word_t     wdata;       // Value written to rd
        logic      illegal;
    } retire_t;

endpackage

// ==== design/rv_decode.sv ====
/*
 * Combinational RV32I decoder, no state and zero latency.
 * Unknown opcodes, funct7 values and branch funct3 codes are flagged
 * illegal with the register write cleared.
 */
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
    input  word_t    instr,     // Instruction register
    output decoded_t dec        // Decoded fields
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_u, imm_j, imm_b;
    alu_op_e    alu_sel;        // Op from funct3, shared by OP and OP_IMM
    logic       f7_ok_op;
    logic       f7_ok_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediates --------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // Alternate funct7 only for SUB and SRA, SRAI
    assign f7_ok_op  = (funct7 == 7'b0) ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign f7_ok_imm = (funct3 != 3'b001 && funct3 != 3'b101) || (funct7 == 7'b0) ||
                       (funct7 == 7'b0100000 && funct3 == 3'b101);

    always_comb begin
        unique case (funct3)
            3'b000:  alu_sel = (funct7[5] && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.imm     = imm_i;            // Most common format
        dec.alu_op  = ALU_ADD;
        dec.br_op   = BR_NONE;
        unique case (opcode)
            OPC_OP: begin
                dec.alu_op  = alu_sel;
                dec.rd_wen  = f7_ok_op;
                dec.illegal = !f7_ok_op;
            end
            OPC_OP_IMM: begin
                dec.alu_op  = alu_sel;
                dec.rhs_imm = 1'b1;
                dec.rd_wen  = f7_ok_imm;
                dec.illegal = !f7_ok_imm;
            end
            OPC_LUI: begin
                dec.rs1     = '0;       // x0 + imm
                dec.imm     = imm_u;
                dec.rhs_imm = 1'b1;
                dec.rd_wen  = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.lhs_pc  = 1'b1;
                dec.rhs_imm = 1'b1;
                dec.rd_wen  = 1'b1;
            end
            OPC_JAL: begin
                dec.imm     = imm_j;
                dec.jal     = 1'b1;
                dec.rd_wen  = 1'b1;     // Link written by control
            end
            OPC_JALR: begin
                dec.jalr    = 1'b1;
                dec.rd_wen  = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                unique case (funct3)
                    3'b000:  dec.br_op = BR_EQ;
                    3'b001:  dec.br_op = BR_NE;
                    3'b100:  dec.br_op = BR_LT;
                    3'b101:  dec.br_op = BR_GE;
                    3'b110:  dec.br_op = BR_LTU;
                    3'b111:  dec.br_op = BR_GEU;
                    default: dec.illegal = 1'b1; // 010 and 011 unused
                endcase
            end
            default: dec.illegal = 1'b1;         // rd_wen stays low
        endcase
    end

endmodule

// ==== design/rv_alu.sv ====
/*
 * Combinational ALU and branch comparator.
 * Shift amounts come from the low 5 bits of the right operand.
 * The comparator looks at the raw register values, not the operands.
 */
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
    input  word_t   lhs,        // Left operand, PC or rs1
    input  word_t   rhs,        // Right operand, imm or rs2
    input  alu_op_e op,
    input  br_op_e  br_op,
    input  word_t   rs1,        // Branch compare sources
    input  word_t   rs2,
    output word_t   res,
    output logic    br_taken
);

    logic [4:0] shamt;
    logic       lt_s;           // Signed less than
    logic       lt_u;           // Unsigned less than
    logic       eq;

    assign shamt = rhs[4:0];

    // Arithmetic and logic ----------------
    always_comb begin
        unique case (op)
            ALU_ADD:  res = lhs + rhs;
            ALU_SUB:  res = lhs - rhs;
            ALU_AND:  res = lhs & rhs;
            ALU_OR:   res = lhs | rhs;
            ALU_XOR:  res = lhs ^ rhs;
            ALU_SLL:  res = lhs << shamt;
            ALU_SRL:  res = lhs >> shamt;
            ALU_SRA:  res = $signed(lhs) >>> shamt;
            ALU_SLT:  res = {{(XLEN_W-1){1'b0}}, $signed(lhs) < $signed(rhs)};
            ALU_SLTU: res = {{(XLEN_W-1){1'b0}}, lhs < rhs};
            default:  res = lhs + rhs;
        endcase
    end

    // Branch decision ---------------------
    assign eq   = (rs1 == rs2);
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    always_comb begin
        unique case (br_op)
            BR_EQ:   br_taken = eq;
            BR_NE:   br_taken = !eq;
            BR_LT:   br_taken = lt_s;
            BR_GE:   br_taken = !lt_s;
            BR_LTU:  br_taken = lt_u;
            BR_GEU:  br_taken = !lt_u;
            default: br_taken = 1'b0;   // Not a branch
        endcase
    end

endmodule

// ==== design/rv_regfile.sv ====
/*
 * Integer register file, 2 async read ports and 1 write port.
 * x0 reads zero. x1 to x31 power up unknown and are not reset,
 * so software must write them before use.
 */
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
    input  logic      g_clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wen,      // Write strobe, one cycle
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [1:31];         // No storage for x0

    // Read ports --------------------------
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Write port --------------------------
    always_ff @(posedge g_clk) begin
        if (wen && waddr != '0) begin   // Writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== design/rv_control.sv ====
/*
 * Control FSM for a multi-cycle core with one instruction in flight.
 * Wishbone classic fetch, then one execute cycle; the retire record
 * is registered on the rd write edge. A fetch error halts the core
 * until reset. PC bits 1:0 are always forced to zero.
 */
`timescale 1ns/10ps

module rv_control import rv_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,

    output logic      wb_cyc,       // Wishbone fetch master
    output logic      wb_stb,
    output word_t     wb_adr,
    input  word_t     wb_dat_i,
    input  logic      wb_ack,
    input  logic      wb_err,

    output word_t     instr,        // To decoder
    input  decoded_t  dec,
    input  word_t     rs1_data,     // From register file
    input  word_t     rs2_data,

    output word_t     alu_lhs,
    output word_t     alu_rhs,
    output alu_op_e   alu_op,
    input  word_t     alu_res,
    input  logic      br_taken,

    output logic      rd_wen,       // Register file write port
    output reg_addr_t rd_addr,
    output word_t     rd_wdata,

    output logic      trs_valid,    // Retire record
    output retire_t   trs,
    output logic      fetch_fault
);

    typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_HALT} state_e;

    state_e  state;
    logic    cyc_q;                 // Bus cycle open
    logic    fault_q;
    logic    trs_valid_q;
    word_t   pc;
    word_t   ir;                    // Instruction register
    retire_t trs_q;
    logic    exec;
    logic    jump;                  // Taken branch or JAL
    word_t   pc_plus4;
    word_t   npc_raw;
    word_t   npc;
    word_t   wdata;

    assign exec = (state == ST_EXECUTE);

    // Datapath selects --------------------
    assign alu_lhs  = dec.lhs_pc  ? pc      : rs1_data;
    assign alu_rhs  = dec.rhs_imm ? dec.imm : rs2_data;
    assign alu_op   = dec.alu_op;

    assign pc_plus4 = pc + 32'd4;
    assign jump     = dec.jal || br_taken;  // br_taken low for non-branches
    assign npc_raw  = dec.jalr ? rs1_data + dec.imm :
                      jump     ? pc + dec.imm       : pc_plus4;
    assign npc      = {npc_raw[XLEN_W-1:2], 2'b00}; // No misaligned PCs

    assign wdata    = (dec.jal || dec.jalr) ? pc_plus4 : alu_res; // Link value

    assign rd_wen   = exec && dec.rd_wen;
    assign rd_addr  = dec.rd;
    assign rd_wdata = wdata;

    // Outputs -----------------------------
    assign wb_cyc      = cyc_q;
    assign wb_stb      = cyc_q;     // Same as cyc, classic single access
    assign wb_adr      = pc;        // Stable while cyc high
    assign instr       = ir;
    assign trs_valid   = trs_valid_q;
    assign trs         = trs_q;
    assign fetch_fault = fault_q;

    // FSM and PC --------------------------
    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            state       <= ST_FETCH;
            cyc_q       <= 1'b0;
            fault_q     <= 1'b0;
            trs_valid_q <= 1'b0;
            pc          <= PC_RESET_ADDR;
        end else begin
            trs_valid_q <= 1'b0;            // One cycle pulse
            unique case (state)
                ST_FETCH: begin
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;      // Open the fetch
                    end else if (wb_err) begin
                        cyc_q   <= 1'b0;
                        fault_q <= 1'b1;
                        state   <= ST_HALT;
                    end else if (wb_ack) begin
                        cyc_q <= 1'b0;
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    pc          <= npc;
                    trs_valid_q <= 1'b1;    // Same edge as rd write
                    state       <= ST_FETCH;
                end
                default: state <= ST_HALT;  // Only reset leaves HALT
            endcase
        end
    end

    // Payload -----------------------------
    always_ff @(posedge g_clk) begin
        if (state == ST_FETCH && cyc_q && wb_ack) begin
            ir <= wb_dat_i;
        end
        if (exec) begin
            trs_q.pc      <= pc;
            trs_q.instr   <= ir;
            trs_q.rd_wen  <= dec.rd_wen;
            trs_q.rd      <= dec.rd;
            trs_q.wdata   <= wdata;
            trs_q.illegal <= dec.illegal;
        end
    end

endmodule

// ==== design/rv_core.sv ====
/*
 * RV32I core top level, instruction fetch over Wishbone classic only.
 * No data port, CSRs or interrupts. Writes are never issued, so
 * wb_we is tied low and wb_sel to all bytes.
 */
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic       g_clk,
    input  logic       rst_n,       // Sync, active low
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output logic [3:0] wb_sel,
    output word_t      wb_adr,
    input  word_t      wb_dat_i,
    input  logic       wb_ack,
    input  logic       wb_err,
    output logic       trs_valid,   // One pulse per retired instruction
    output retire_t    trs,
    output logic       fetch_fault  // Sticky until reset
);

    word_t     instr;
    decoded_t  dec;
    word_t     rs1_data, rs2_data;
    word_t     alu_lhs, alu_rhs, alu_res;
    alu_op_e   alu_op;
    logic      br_taken;
    logic      rd_wen;
    reg_addr_t rd_addr;
    word_t     rd_wdata;

    assign wb_we  = 1'b0;           // Read only master
    assign wb_sel = 4'hF;

    rv_control u_control (
        .g_clk, .rst_n,
        .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack, .wb_err,
        .instr, .dec, .rs1_data, .rs2_data,
        .alu_lhs, .alu_rhs, .alu_op, .alu_res, .br_taken,
        .rd_wen, .rd_addr, .rd_wdata,
        .trs_valid, .trs, .fetch_fault
    );

    rv_decode u_decode (.instr, .dec);

    rv_alu u_alu (
        .lhs(alu_lhs), .rhs(alu_rhs), .op(alu_op), .br_op(dec.br_op),
        .rs1(rs1_data), .rs2(rs2_data), .res(alu_res), .br_taken
    );

    rv_regfile u_regfile (
        .g_clk,
        .rs1_addr(dec.rs1), .rs2_addr(dec.rs2),
        .rs1_data, .rs2_data,
        .wen(rd_wen), .waddr(rd_addr), .wdata(rd_wdata)
    );

endmodule

// ==== verification/rv_core_sva.sv ====
/*
 * Bus and fault assertions, bound into the core top level.
 * All checks are off while reset is low.
 */
`timescale 1ns/10ps

module rv_core_sva import rv_pkg::*; (
    input logic  g_clk,
    input logic  rst_n,
    input logic  wb_cyc,
    input logic  wb_stb,
    input word_t wb_adr,
    input logic  wb_ack,
    input logic  wb_err,
    input logic  trs_valid,
    input logic  fetch_fault
);

    // Wishbone classic ---------------
    a_cyc_stb: assert property (@(posedge g_clk) disable iff (!rst_n) wb_cyc == wb_stb)
        else $error("wb_cyc and wb_stb differ");

    a_adr_hold: assert property (@(posedge g_clk) disable iff (!rst_n)
        wb_cyc && !wb_ack && !wb_err |=> wb_cyc && $stable(wb_adr))
        else $error("fetch dropped or address moved before ack");

    // Retire and fault ---------------
    a_trs_after_ack: assert property (@(posedge g_clk) disable iff (!rst_n)
        trs_valid |-> $past(wb_cyc && wb_ack, 2))
        else $error("retire without an ack one cycle before");

    a_halt: assert property (@(posedge g_clk) disable iff (!rst_n) fetch_fault |-> !wb_cyc)
        else $error("bus cycle after fetch fault");

endmodule

// ==== verification/rv_checker.sv ====
/*
 * Reference model of the core, driven only by the bus and retire record.
 * Assumes each program clears x1 to x31 before reading them.
 * Counters survive reset; the model state does not.
 */
`timescale 1ns/10ps

module rv_checker import rv_pkg::*; (
    input  logic       g_clk,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_we,
    input  logic [3:0] wb_sel,
    input  word_t      wb_adr,
    input  word_t      wb_dat_i,
    input  logic       wb_ack,
    input  logic       trs_valid,
    input  retire_t    trs,
    output int         err_count,
    output int         retire_count,
    output int         illegal_count
);

    word_t m_pc;                    // Model PC
    word_t m_regs [0:31];           // Model registers, x0 kept zero
    word_t fetched;                 // Word of the last acked fetch
    logic  ack_d1, ack_d2;          // Ack history, two edges deep
    int    errors   = 0;
    int    retired  = 0;
    int    illegals = 0;

    assign err_count     = errors;
    assign retire_count  = retired;
    assign illegal_count = illegals;

    // Reference ALU, RV32I funct3 encoding
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare(input string name, input word_t exp, input word_t got);
        if (exp !== got) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // Expected record from the fetched word and the model state
    task automatic check_retire();
        word_t      ins, a, b, imm_i, wd, npc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       wen, ill, taken;
        reg_addr_t  rd;
        ins   = fetched;
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        wen   = 1'b1;
        ill   = 1'b0;
        taken = 1'b0;
        wd    = '0;
        npc   = m_pc + 32'd4;
        case (ins[6:0])
            OPC_OP: begin
                ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                wd  = alu_ref(f3, ins[30], a, b);
            end
            OPC_OP_IMM: begin
                ill = (f3 == 3'd1 && f7 != 7'h00) ||
                      (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                wd  = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            end
            OPC_LUI:   wd = {ins[31:12], 12'b0};
            OPC_AUIPC: wd = m_pc + {ins[31:12], 12'b0};
            OPC_JAL: begin
                wd  = m_pc + 32'd4;     // Link
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                wd  = m_pc + 32'd4;
                npc = a + imm_i;
            end
            OPC_BRANCH: begin
                wen = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: ill = 1'b1;
                endcase
                if (taken) npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: ill = 1'b1;        // Not in the kept set
        endcase
        if (ill) wen = 1'b0;
        npc[1:0] = 2'b00;               // PC always word aligned
        compare("trs.pc", m_pc, trs.pc);
        compare("trs.instr", ins, trs.instr);
        compare("trs.rd_wen", word_t'(wen), word_t'(trs.rd_wen));
        compare("trs.illegal", word_t'(ill), word_t'(trs.illegal));
        if (wen) begin
            compare("trs.rd", word_t'(rd), word_t'(trs.rd));
            compare("trs.wdata", wd, trs.wdata);
            if (rd != '0) m_regs[rd] = wd;
        end
        if (ill) illegals++;
        retired++;
        m_pc = npc;
    endtask

    // Watch the bus and the retire port ---
    always @(posedge g_clk) begin
        if (!rst_n) begin
            m_pc = PC_RESET_ADDR;
            foreach (m_regs[i]) m_regs[i] = '0;
            ack_d1 = 1'b0;
            ack_d2 = 1'b0;
        end else begin
            if (trs_valid) begin
                if (!ack_d2) begin
                    $display("Error: trs_valid came without a fetch ack one cycle before");
                    errors++;
                end
                check_retire();
            end
            ack_d2 = ack_d1;
            ack_d1 = wb_cyc && wb_ack;
            if (ack_d1) begin
                fetched = wb_dat_i;
                compare("wb_adr", m_pc, wb_adr);  // Fetch follows model PC
                compare("wb_we", 32'h0, word_t'(wb_we));   // Read only master
                compare("wb_sel", 32'hF, word_t'(wb_sel));
            end
        end
    end

endmodule

// ==== verification/tb_rv_core.sv ====
/*
 * Testbench for the core with a 256-word Wishbone program memory.
 * Memory index is address bits 9:2 and wraps around.
 * Programs start at the reset PC with a prologue clearing x1 to x31.
 */
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

    localparam int MAX_WAIT    = 3;                       // Wait states per fetch
    localparam int TOTAL_INSTR = 1 + 3 * 300 + 200 + 20 + 20;
    localparam int TIMEOUT     = TOTAL_INSTR * (MAX_WAIT + 3) + 50 + 100;

    logic    g_clk, rst_n;
    logic    wb_cyc, wb_stb, wb_we, wb_ack, wb_err, trs_valid, fetch_fault;
    logic [3:0] wb_sel;
    word_t   wb_adr, wb_dat_i;
    retire_t trs;
    int      chk_errors, retire_count, illegal_count;

    integer  seed;
    integer  saved_seed;
    word_t   mem [0:255];
    int      max_wait = 0;
    logic    err_en   = 1'b0;      // Answer err_adr with wb_err
    word_t   err_adr  = '0;
    logic    busy     = 1'b0;
    int      wait_left;
    int      cycles       = 0;
    int      tb_fails     = 0;
    int      tests_failed = 0;
    int      err_mark     = 0;

    rv_core dut (.*);

    rv_checker u_checker (
        .g_clk, .rst_n, .wb_cyc, .wb_we, .wb_sel, .wb_adr, .wb_dat_i, .wb_ack,
        .trs_valid, .trs,
        .err_count(chk_errors), .retire_count, .illegal_count
    );

    bind rv_core rv_core_sva u_sva (
        .g_clk, .rst_n, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_err,
        .trs_valid, .fetch_fault
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: no finish after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Wishbone slave -----------------
    always @(posedge g_clk) begin
        #1;
        if (!wb_cyc) begin
            wb_ack = 1'b0;
            wb_err = 1'b0;
            busy   = 1'b0;
        end else begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = (max_wait > 0) ? $unsigned($random(seed)) % (max_wait + 1) : 0;
            end
            if (wait_left == 0) begin
                wb_dat_i = mem[wb_adr[9:2]];
                if (err_en && wb_adr == err_adr) wb_err = 1'b1;
                else wb_ack = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    // Kind 0 ALU only, 1 control heavy, 2 with illegal words
    function automatic word_t rand_instr(input int kind);
        word_t      r, off;
        int         sel;
        logic [2:0] f3;
        logic [11:0] imm;
        r   = $random(seed);
        sel = $unsigned($random(seed)) % 16;
        f3  = r[14:12];
        off = 32'd4 * (1 + r[3:0]);    // Forward only
        if (kind == 2 && sel < 4) begin
            case (sel)
                0:       return 32'h0000_0000;
                1:       return 32'hFFFF_FFFF;
                2:       return {r[31:7], 7'b0000011};              // Load, not kept
                default: return {r[31:15], 3'b010, r[11:7], OPC_BRANCH};
            endcase
        end
        if (kind == 1 && sel >= 8) begin
            if (sel < 12) begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
                return {1'b0, off[10:5], r[24:15], f3, off[4:1], 1'b0, OPC_BRANCH};
            end
            if (sel < 14) return {1'b0, off[10:1], 1'b0, 8'b0, r[11:7], OPC_JAL};
            return {r[31:15], 3'b000, r[11:7], OPC_JALR};
        end
        case (sel % 6)
            0, 1: return {(f3 == 3'd0 || f3 == 3'd5) && r[30] ? 7'h20 : 7'h00,
                          r[24:15], f3, r[11:7], OPC_OP};
            2, 3: begin
                imm = r[31:20];
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                if (f3 == 3'd5) imm[11:5] = r[30] ? 7'h20 : 7'h00;
                return {imm, r[19:15], f3, r[11:7], OPC_OP_IMM};
            end
            4:       return {r[31:7], OPC_LUI};
            default: return {r[31:7], OPC_AUIPC};
        endcase
    endfunction

    task automatic fill_program(input int kind);
        for (int i = 0; i < 256; i++) mem[i] = rand_instr(kind);
        for (int i = 1; i < 32; i++) mem[63 + i] = {12'h0, 5'd0, 3'b000, 5'(i), OPC_OP_IMM};
    endtask

    task automatic apply_reset();
        @(posedge g_clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge g_clk);
            if (i > 0 && {wb_cyc, trs_valid, fetch_fault} !== 3'b000) begin
                $display("Error: wb_cyc %h trs_valid %h fetch_fault %h in reset, expected 0",
                         wb_cyc, trs_valid, fetch_fault);
                tb_fails++;
            end
        end
        @(posedge g_clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic run_retires(input int n);
        int target;
        target = retire_count + n;
        while (retire_count < target) @(negedge g_clk);
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = tb_fails + chk_errors - err_mark;
        $display("Test %0d %s %s", num, name, (errs == 0) ? "passed" : "failed");
        if (errs != 0) tests_failed++;
        err_mark = tb_fails + chk_errors;
    endtask

    // Test sequence ------------------
    initial begin
        int base;
        int ill_base;
        logic cyc_seen;
        seed     = 32'h10dded98;
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_err   = 1'b0;
        wb_dat_i = '0;

        fill_program(0);
        apply_reset();
        @(negedge g_clk);
        @(negedge g_clk);
        if (wb_cyc !== 1'b1) begin
            $display("Error: wb_cyc expected 1 got %h", wb_cyc);
            tb_fails++;
        end
        if (wb_adr !== PC_RESET_ADDR) begin
            $display("Error: wb_adr expected %h got %h", PC_RESET_ADDR, wb_adr);
            tb_fails++;
        end
        run_retires(1);
        if (trs.pc !== PC_RESET_ADDR) begin
            $display("Error: trs.pc expected %h got %h", PC_RESET_ADDR, trs.pc);
            tb_fails++;
        end
        finish_test(1, "reset");

        saved_seed = seed;              // Test 4 reruns this program
        fill_program(0);
        apply_reset();
        run_retires(300);
        finish_test(2, "arithmetic");

        fill_program(1);
        apply_reset();
        run_retires(300);
        finish_test(3, "control flow");

        seed = saved_seed;
        fill_program(0);
        max_wait = MAX_WAIT;
        apply_reset();
        run_retires(300);
        finish_test(4, "wait states");

        fill_program(2);
        ill_base = illegal_count;
        apply_reset();
        run_retires(200);
        if (illegal_count == ill_base) begin
            $display("No illegal instruction retired in the illegal opcode test");
            tb_fails++;
        end
        finish_test(5, "illegal opcode");

        fill_program(0);
        err_en  = 1'b1;
        err_adr = PC_RESET_ADDR + 32'd80;   // Inside the prologue
        apply_reset();
        while (!wb_err) @(negedge g_clk);
        @(negedge g_clk);
        if (fetch_fault !== 1'b1) begin
            $display("Error: fetch_fault expected 1 got %h", fetch_fault);
            tb_fails++;
        end
        base     = retire_count;
        cyc_seen = 1'b0;
        repeat (50) begin
            @(negedge g_clk);
            if (wb_cyc) cyc_seen = 1'b1;
        end
        if (cyc_seen || retire_count != base) begin
            $display("Core kept fetching or retiring after a fetch fault");
            tb_fails++;
        end
        err_en = 1'b0;
        apply_reset();
        run_retires(20);
        finish_test(6, "fetch error");

        $display("Tests run 6, failed %0d, check errors %0d, retired %0d",
                 tests_failed, tb_fails + chk_errors, retire_count);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/rv_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_control.sv
design/rv_core.sv
verification/rv_core_sva.sv
verification/rv_checker.sv
verification/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_rv_core -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_rv_core | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
